/* hdl/alu.sv */
`timescale 1ns/10ps
`include "ex_settings.svh"

module alu
    import ex_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   res
);

    localparam int SHAMT_W = $clog2(`EX_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic               equal;

    assign shamt       = b[SHAMT_W-1:0];   // only the low bits count for shifts
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;
    assign equal       = a == b;

    always_comb begin
        case (op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_SLL:  res = a << shamt;
            ALU_SLT:  res = word_t'(lt_signed);
            ALU_SLTU: res = word_t'(lt_unsigned);
            ALU_XOR:  res = a ^ b;
            ALU_SRL:  res = a >> shamt;
            ALU_SRA:  res = word_t'($signed(a) >>> shamt);
            ALU_OR:   res = a | b;
            ALU_AND:  res = a & b;
            ALU_EQ:   res = word_t'(equal);
            default:  res = '0;   // unused codes
        endcase
    end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/10ps

module branch_unit
    import ex_pkg::*;
(
    input  word_t pc,
    input  word_t imm,
    input  logic  cmp,      // compare outcome, already corrected for inversion
    input  logic  branch,
    input  logic  jump,
    output logic  taken,
    output word_t target
);

    // jal and jalr always leave, conditional branches only on a true compare
    assign taken  = jump | (branch & cmp);

    assign target = pc + imm;   // jalr gets its base folded in by decode

endmodule

/* hdl/ex_perf_counter.sv */
`timescale 1ns/10ps

module ex_perf_counter
    import ex_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic accept_pulse,
    input  logic squash_pulse,
    input  logic redirect_valid,
    output cnt_t accepted_count,
    output cnt_t squashed_count,
    output cnt_t redirect_count
);

    // plain wrapping counters, software takes deltas
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            accepted_count <= '0;
            squashed_count <= '0;
            redirect_count <= '0;
        end else begin
            if (accept_pulse)
                accepted_count <= accepted_count + 1'b1;
            if (squash_pulse)
                squashed_count <= squashed_count + 1'b1;
            if (redirect_valid)
                redirect_count <= redirect_count + 1'b1;
        end
    end

endmodule

/* hdl/ex_pkg.sv */
`include "ex_settings.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]  word_t;     // data values and pc
    typedef logic [`EX_REG_W-1:0] reg_idx_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [3:0]           csr_wen_t;  // one enable per csr port
    typedef logic [`EX_CNT_W-1:0] cnt_t;

    // alu operation codes as decode produces them
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_EQ   = 4'd10   // 1 when a == b
    } alu_op_t;

    typedef enum logic {
        RD_RUN,
        RD_SQUASH   // dropping wrong-path ops until the target shows up
    } redirect_state_t;

endpackage

/* hdl/ex_settings.svh */
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// datapath width, also the pc width
`define EX_XLEN 32

// destination register index
`define EX_REG_W 5

// performance counters wrap at this width
`define EX_CNT_W 32

`endif

/* hdl/ex_stage.sv */
`timescale 1ns/10ps

module ex_stage
    import ex_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  logic     kill,
    input  word_t    pc,
    input  word_t    a,
    input  word_t    b,
    input  word_t    imm,
    input  word_t    rd_value,      // link value for jal/jalr
    input  word_t    store_data,
    input  alu_op_t  alu_op,
    input  logic     inv,
    input  logic     branch,
    input  logic     jump,
    input  reg_idx_t rd,
    input  funct3_t  funct3,
    input  csr_wen_t csr_wen,
    input  logic     reg_wen,
    input  logic     mem_wen,
    input  logic     mem_ren,
    output logic     out_valid,
    input  logic     out_ready,
    output word_t    result,
    output word_t    rd_value_out,
    output word_t    store_data_out,
    output reg_idx_t rd_out,
    output funct3_t  funct3_out,
    output csr_wen_t csr_wen_out,
    output logic     reg_wen_out,
    output logic     mem_wen_out,
    output logic     mem_ren_out,
    output logic     branch_out,
    output logic     jump_out,
    output logic     redirect_valid,
    output word_t    redirect_pc,
    output logic     accept_pulse,
    output logic     squash_pulse
);

    word_t   pc_r;
    word_t   a_r;
    word_t   b_r;
    word_t   imm_r;
    alu_op_t alu_op_r;
    logic    inv_r;
    word_t   alu_res;
    logic    taken;

    assign in_ready     = out_ready;   // no skid buffer, stall straight through
    assign accept_pulse = in_valid & in_ready;
    assign squash_pulse = accept_pulse & kill;

    // operands and pass-through payload
    always_ff @(posedge clock) begin
        if (accept_pulse) begin
            pc_r           <= pc;
            a_r            <= a;
            b_r            <= b;
            imm_r          <= imm;
            alu_op_r       <= alu_op;
            inv_r          <= inv;
            rd_value_out   <= rd_value;
            store_data_out <= store_data;
            rd_out         <= rd;
            funct3_out     <= funct3;
        end
    end

    // valid and everything with a side effect, wiped for a killed op
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid   <= 1'b0;
            csr_wen_out <= '0;
            reg_wen_out <= 1'b0;
            mem_wen_out <= 1'b0;
            mem_ren_out <= 1'b0;
            branch_out  <= 1'b0;
            jump_out    <= 1'b0;
        end else if (out_ready) begin
            out_valid   <= in_valid & ~kill;   // empty slot if nothing came in
            if (accept_pulse) begin
                csr_wen_out <= kill ? '0 : csr_wen;
                reg_wen_out <= reg_wen & ~kill;
                mem_wen_out <= mem_wen & ~kill;
                mem_ren_out <= mem_ren & ~kill;
                branch_out  <= branch & ~kill;
                jump_out    <= jump & ~kill;
            end
        end
    end

    alu u_alu (
        .a   (a_r),
        .b   (b_r),
        .op  (alu_op_r),
        .res (alu_res)
    );

    // inv turns beq/blt/bltu into bne/bge/bgeu
    assign result = alu_res ^ word_t'(inv_r);

    branch_unit u_branch_unit (
        .pc     (pc_r),
        .imm    (imm_r),
        .cmp    (result[0]),
        .branch (branch_out),
        .jump   (jump_out),
        .taken  (taken),
        .target (redirect_pc)
    );

    assign redirect_valid = out_valid & out_ready & taken;   // fires once, on the transfer

endmodule

/* hdl/ex_top.sv */
`timescale 1ns/10ps

module ex_top
    import ex_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  word_t    pc,
    input  word_t    a,
    input  word_t    b,
    input  word_t    imm,
    input  word_t    rd_value,
    input  word_t    store_data,
    input  alu_op_t  alu_op,
    input  logic     inv,
    input  logic     branch,
    input  logic     jump,
    input  reg_idx_t rd,
    input  funct3_t  funct3,
    input  csr_wen_t csr_wen,
    input  logic     reg_wen,
    input  logic     mem_wen,
    input  logic     mem_ren,
    output logic     out_valid,
    input  logic     out_ready,
    output word_t    result,
    output word_t    rd_value_out,
    output word_t    store_data_out,
    output reg_idx_t rd_out,
    output funct3_t  funct3_out,
    output csr_wen_t csr_wen_out,
    output logic     reg_wen_out,
    output logic     mem_wen_out,
    output logic     mem_ren_out,
    output logic     branch_out,
    output logic     jump_out,
    output logic     redirect_valid,
    output word_t    redirect_pc,
    output cnt_t     accepted_count,
    output cnt_t     squashed_count,
    output cnt_t     redirect_count
);

    logic kill;
    logic accept_pulse;
    logic squash_pulse;

    ex_stage u_ex_stage (
        .clock          (clock),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .kill           (kill),
        .pc             (pc),
        .a              (a),
        .b              (b),
        .imm            (imm),
        .rd_value       (rd_value),
        .store_data     (store_data),
        .alu_op         (alu_op),
        .inv            (inv),
        .branch         (branch),
        .jump           (jump),
        .rd             (rd),
        .funct3         (funct3),
        .csr_wen        (csr_wen),
        .reg_wen        (reg_wen),
        .mem_wen        (mem_wen),
        .mem_ren        (mem_ren),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .result         (result),
        .rd_value_out   (rd_value_out),
        .store_data_out (store_data_out),
        .rd_out         (rd_out),
        .funct3_out     (funct3_out),
        .csr_wen_out    (csr_wen_out),
        .reg_wen_out    (reg_wen_out),
        .mem_wen_out    (mem_wen_out),
        .mem_ren_out    (mem_ren_out),
        .branch_out     (branch_out),
        .jump_out       (jump_out),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .accept_pulse   (accept_pulse),
        .squash_pulse   (squash_pulse)
    );

    // watches the input side, kill goes back combinationally
    redirect_ctrl u_redirect_ctrl (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .pc             (pc),
        .kill           (kill)
    );

    ex_perf_counter u_ex_perf_counter (
        .clock          (clock),
        .reset          (reset),
        .accept_pulse   (accept_pulse),
        .squash_pulse   (squash_pulse),
        .redirect_valid (redirect_valid),
        .accepted_count (accepted_count),
        .squashed_count (squashed_count),
        .redirect_count (redirect_count)
    );

endmodule

/* hdl/redirect_ctrl.sv */
`timescale 1ns/10ps

module redirect_ctrl
    import ex_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  redirect_valid,
    input  word_t redirect_pc,
    input  logic  in_valid,
    input  logic  in_ready,
    input  word_t pc,
    output logic  kill
);

    redirect_state_t state;
    redirect_state_t state_next;
    word_t           target_r;
    word_t           cmp_target;
    logic            accept;
    logic            match;

    assign accept = in_valid & in_ready;

    // a redirect leaving this cycle already decides the fate of the incoming op
    assign cmp_target = redirect_valid ? redirect_pc : target_r;
    assign match      = pc == cmp_target;

    assign kill = accept & ~match & ((state == RD_SQUASH) | redirect_valid);

    always_comb begin
        state_next = state;
        if (redirect_valid) begin
            // target accepted in the very same cycle closes the window at once
            state_next = (accept && match) ? RD_RUN : RD_SQUASH;
        end else if (state == RD_SQUASH && accept && match) begin
            state_next = RD_RUN;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= RD_RUN;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (redirect_valid)
            target_r <= redirect_pc;   // only looked at while squashing
    end

endmodule

/* list.f */
+incdir+hdl
hdl/ex_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/redirect_ctrl.sv
hdl/ex_perf_counter.sv
hdl/ex_stage.sv
hdl/ex_top.sv
sim/ex_top_chk.sv
sim/ex_top_tb.sv

/* run.sh */
#!/bin/sh
# build and run the ex_top testbench with Verilator, the verdict comes from the log
rm -rf obj_dir sim.log
verilator --binary --assert -j 0 --top-module ex_top_tb -f list.f -o ex_top_sim || exit 1
./obj_dir/ex_top_sim +verilator+error+limit+10000 > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
echo "simulation passed"

/* sim/ex_top_chk.sv */
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_top_chk
    import ex_pkg::*;
(
    input logic  clock,
    input logic  reset,
    input logic  in_valid,
    input logic  in_ready,
    input logic  out_valid,
    input logic  out_ready,
    input logic  kill,
    input word_t pc,
    input logic  redirect_valid,
    input word_t redirect_pc,
    input logic  branch_out,
    input logic  jump_out,
    input logic [3*`EX_XLEN+`EX_REG_W+11:0] payload   // all output fields side by side
);

    int fail_ready = 0;
    int fail_hold = 0;
    int fail_redirect = 0;
    int fail_kill = 0;
    int fail_target = 0;

    ready_follows: assert property (@(posedge clock) disable iff (reset)
        in_ready == out_ready)
        else begin
            $error("in_ready differs from out_ready");
            fail_ready = fail_ready + 1;
        end

    // a stalled result must not move
    output_holds: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(payload))
        else begin
            $error("output changed while stalled");
            fail_hold = fail_hold + 1;
        end

    redirect_on_transfer: assert property (@(posedge clock) disable iff (reset)
        redirect_valid |-> out_valid && out_ready && (branch_out || jump_out))
        else begin
            $error("redirect without a transferred branch or jump");
            fail_redirect = fail_redirect + 1;
        end

    killed_op_dropped: assert property (@(posedge clock) disable iff (reset)
        in_valid && in_ready && kill |=> !out_valid)
        else begin
            $error("killed operation reached the output");
            fail_kill = fail_kill + 1;
        end

    // the op sitting at the target address survives its own redirect
    target_kept: assert property (@(posedge clock) disable iff (reset)
        in_valid && in_ready && redirect_valid && pc == redirect_pc |-> !kill)
        else begin
            $error("operation at the redirect target was killed");
            fail_target = fail_target + 1;
        end

endmodule

bind ex_top ex_top_chk chk0 (
    .clock          (clock),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .kill           (kill),
    .pc             (pc),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .branch_out     (branch_out),
    .jump_out       (jump_out),
    .payload        ({result, rd_value_out, store_data_out, rd_out, funct3_out, csr_wen_out,
                      reg_wen_out, mem_wen_out, mem_ren_out, branch_out, jump_out})
);

/* sim/ex_top_tb.sv */
`timescale 1ns/10ps

module ex_top_tb
    import ex_pkg::*;
();

    localparam int STIM_CYCLES = 2000;
    localparam int MAX_CYCLES  = 3000;   // reset, stimulus and drain with margin

    typedef struct packed {
        word_t    result;
        word_t    rd_value;
        word_t    store_data;
        word_t    target;
        reg_idx_t rd;
        funct3_t  funct3;
        csr_wen_t csr_wen;
        logic     reg_wen;
        logic     mem_wen;
        logic     mem_ren;
        logic     branch;
        logic     jump;
        logic     taken;
    } expect_t;

    logic     clock = 1'b0;
    logic     reset = 1'b1;
    logic     in_valid = 1'b0;
    logic     out_ready = 1'b0;
    word_t    pc = '0;
    word_t    a = '0;
    word_t    b = '0;
    word_t    imm = '0;
    word_t    rd_value = '0;
    word_t    store_data = '0;
    alu_op_t  alu_op = ALU_ADD;
    logic     inv = 1'b0;
    logic     branch = 1'b0;
    logic     jump = 1'b0;
    reg_idx_t rd = '0;
    funct3_t  funct3 = '0;
    csr_wen_t csr_wen = '0;
    logic     reg_wen = 1'b0;
    logic     mem_wen = 1'b0;
    logic     mem_ren = 1'b0;

    logic     in_ready;
    logic     out_valid;
    word_t    result;
    word_t    rd_value_out;
    word_t    store_data_out;
    reg_idx_t rd_out;
    funct3_t  funct3_out;
    csr_wen_t csr_wen_out;
    logic     reg_wen_out;
    logic     mem_wen_out;
    logic     mem_ren_out;
    logic     branch_out;
    logic     jump_out;
    logic     redirect_valid;
    word_t    redirect_pc;
    cnt_t     accepted_count;
    cnt_t     squashed_count;
    cnt_t     redirect_count;

    expect_t     exp_q[$];              // at most one entry with a one-cycle stage
    logic        stim_on = 1'b0;
    logic        sq_on = 1'b0;          // model of the squash window
    word_t       sq_target = '0;
    word_t       last_pc = 32'h0000_1000;
    logic [31:0] rng = 32'hac68;
    cnt_t        acc_model = '0;
    cnt_t        squash_model = '0;
    cnt_t        redir_model = '0;
    int          errors = 0;
    int          cycles = 0;

    always #2 clock = ~clock;

    ex_top dut0 (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift(rng);
        r   = rng;
    endtask

    // expected alu result, straight from the rv32 definitions
    function automatic word_t alu_model(input alu_op_t op, input word_t x, input word_t y);
        case (op)
            ALU_ADD:  return x + y;
            ALU_SUB:  return x - y;
            ALU_SLL:  return x << y[4:0];
            ALU_SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (x < y) ? 32'd1 : 32'd0;
            ALU_XOR:  return x ^ y;
            ALU_SRL:  return x >> y[4:0];
            ALU_SRA:  return $unsigned($signed(x) >>> y[4:0]);
            ALU_OR:   return x | y;
            ALU_AND:  return x & y;
            ALU_EQ:   return (x == y) ? 32'd1 : 32'd0;
            default:  return '0;
        endcase
    endfunction

    function automatic int mismatch(input string name, input word_t got, input word_t want);
        logic bad;
        bad = got !== want;
        assert (!bad) else $display("Error: %s got %h expected %h", name, got, want);
        return int'(bad);
    endfunction

    always @(posedge clock) begin
        expect_t     head;
        expect_t     entry;
        logic        accept;
        logic        redir;
        logic        match;
        logic        kill;
        word_t       redir_pc;
        word_t       opa;
        logic [31:0] r;
        logic [31:0] op_sel;
        if (!reset) begin
            accept   = in_valid && out_ready;
            redir    = 1'b0;
            redir_pc = '0;
            errors  += mismatch("out_valid", word_t'(out_valid), word_t'(exp_q.size() != 0));
            if (out_valid && out_ready && exp_q.size() != 0) begin
                head     = exp_q.pop_front();
                redir    = head.taken;
                redir_pc = head.target;
                errors  += mismatch("result", result, head.result);
                errors  += mismatch("rd_value_out", rd_value_out, head.rd_value);
                errors  += mismatch("store_data_out", store_data_out, head.store_data);
                errors  += mismatch("rd_out", word_t'(rd_out), word_t'(head.rd));
                errors  += mismatch("funct3_out", word_t'(funct3_out), word_t'(head.funct3));
                errors  += mismatch("csr_wen_out", word_t'(csr_wen_out), word_t'(head.csr_wen));
                errors  += mismatch("reg_wen_out", word_t'(reg_wen_out), word_t'(head.reg_wen));
                errors  += mismatch("mem_wen_out", word_t'(mem_wen_out), word_t'(head.mem_wen));
                errors  += mismatch("mem_ren_out", word_t'(mem_ren_out), word_t'(head.mem_ren));
                errors  += mismatch("branch_out", word_t'(branch_out), word_t'(head.branch));
                errors  += mismatch("jump_out", word_t'(jump_out), word_t'(head.jump));
                if (redir)
                    errors += mismatch("redirect_pc", redirect_pc, redir_pc);
            end
            errors += mismatch("redirect_valid", word_t'(redirect_valid), word_t'(redir));

            // squash window, a redirect in this cycle already judges the incoming op
            match = pc == (redir ? redir_pc : sq_target);
            kill  = accept && !match && (sq_on || redir);
            if (redir) begin
                sq_on     = !(accept && match);
                sq_target = redir_pc;
            end else if (sq_on && accept && match) begin
                sq_on = 1'b0;
            end
            acc_model    = acc_model + cnt_t'(accept);
            squash_model = squash_model + cnt_t'(kill);
            redir_model  = redir_model + cnt_t'(redir);

            if (accept && !kill) begin
                entry.result     = alu_model(alu_op, a, b) ^ word_t'(inv);
                entry.rd_value   = rd_value;
                entry.store_data = store_data;
                entry.target     = pc + imm;
                entry.rd         = rd;
                entry.funct3     = funct3;
                entry.csr_wen    = csr_wen;
                entry.reg_wen    = reg_wen;
                entry.mem_wen    = mem_wen;
                entry.mem_ren    = mem_ren;
                entry.branch     = branch;
                entry.jump       = jump;
                entry.taken      = jump || (branch && entry.result[0]);
                exp_q.push_back(entry);
            end

            draw(r);
            out_ready <= r[2:0] != 3'd0;   // stall about one cycle in eight
            if (accept || !in_valid) begin
                draw(r);
                in_valid <= stim_on && r[1:0] != 2'd0;
                if (sq_on && r[3:2] == 2'd0)
                    last_pc = sq_target;   // fetch finally follows the redirect
                else
                    last_pc = last_pc + 32'd4;
                pc <= last_pc;
                draw(r);
                opa = r;
                a   <= r;
                draw(r);
                b <= (r[31:30] == 2'd0) ? opa : r;   // equal operands now and then
                draw(r);
                op_sel  = r % 32'd11;
                alu_op  <= alu_op_t'(op_sel[3:0]);
                inv     <= r[8];
                branch  <= r[13:9] == 5'd0;    // rare, so squash windows close
                jump    <= r[19:14] == 6'd0;
                rd      <= r[24:20];
                funct3  <= r[27:25];
                csr_wen <= r[31:28];
                draw(r);
                // target on the fall-through op now and then, so it meets its own redirect
                imm     <= (r[17:16] == 2'd0) ? 32'd4 : {{20{r[12]}}, r[12:3], 2'b00};
                reg_wen <= r[13];
                mem_wen <= r[14];
                mem_ren <= r[15];
                draw(r);
                rd_value <= r;
                draw(r);
                store_data <= r;
            end
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int end_errors;
        int chk_errors;
        end_errors = 0;
        repeat (16) @(posedge clock);
        end_errors += mismatch("out_valid", word_t'(out_valid), '0);
        end_errors += mismatch("redirect_valid", word_t'(redirect_valid), '0);
        end_errors += mismatch("accepted_count", accepted_count, '0);
        reset   <= 1'b0;
        stim_on <= 1'b1;
        repeat (STIM_CYCLES) @(posedge clock);
        stim_on <= 1'b0;
        while (in_valid || out_valid)
            @(posedge clock);
        repeat (2) @(posedge clock);   // counters lag their pulses by one edge
        end_errors += mismatch("accepted_count", accepted_count, acc_model);
        end_errors += mismatch("squashed_count", squashed_count, squash_model);
        end_errors += mismatch("redirect_count", redirect_count, redir_model);
        chk_errors = dut0.chk0.fail_ready + dut0.chk0.fail_hold + dut0.chk0.fail_redirect
                   + dut0.chk0.fail_kill + dut0.chk0.fail_target;
        $display("errors: scoreboard %0d, end of run %0d, assertions %0d",
                 errors, end_errors, chk_errors);
        if (errors + end_errors + chk_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
